// File: hdl/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath word width
`define MIPS_XLEN 32

// General purpose registers, r0 reads as zero
`define MIPS_NREGS 32

// Address of the first fetch after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: hdl/isa_pkg.sv
package isa_pkg;

	// Register format
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	// Immediate format
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// One instruction word, two views of the same bits
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} inst_t;

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL funct field
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// File: hdl/pipe_pkg.sv
package pipe_pkg;

	// ALU operations, decode to execute
	localparam logic [3:0] ALU_ADD = 4'd0;
	localparam logic [3:0] ALU_SUB = 4'd1;
	localparam logic [3:0] ALU_AND = 4'd2;
	localparam logic [3:0] ALU_OR  = 4'd3;
	localparam logic [3:0] ALU_XOR = 4'd4;
	localparam logic [3:0] ALU_SLT = 4'd5;
	localparam logic [3:0] ALU_SLL = 4'd6;
	localparam logic [3:0] ALU_LUI = 4'd7;

	// Data memory access, carried through to mem
	localparam logic [1:0] MEM_NONE  = 2'd0;
	localparam logic [1:0] MEM_LOAD  = 2'd1;
	localparam logic [1:0] MEM_STORE = 2'd2;

endpackage

// File: hdl/reg_file.sv
`include "mips_cfg.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  we,
	input  logic [4:0]            waddr,
	input  logic [`MIPS_XLEN-1:0] wdata,
	input  logic [4:0]            raddr1,
	input  logic [4:0]            raddr2,
	output logic [`MIPS_XLEN-1:0] rdata1,
	output logic [`MIPS_XLEN-1:0] rdata2
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

	always_ff @(posedge clk) begin
		if (we && waddr != 5'd0)
			regs[waddr] <= wdata;
	end

	// Write-back data goes straight through to a same-cycle read
	always_comb begin
		if (raddr1 == 5'd0)
			rdata1 = '0;
		else if (we && waddr == raddr1)
			rdata1 = wdata;
		else
			rdata1 = regs[raddr1];
		if (raddr2 == 5'd0)
			rdata2 = '0;
		else if (we && waddr == raddr2)
			rdata2 = wdata;
		else
			rdata2 = regs[raddr2];
	end

	a_waddr_known: assert property (@(posedge clk) disable iff (!arst_n)
		we |-> !$isunknown(waddr));

endmodule

// File: hdl/fetch_stage.sv
`include "mips_cfg.svh"

module fetch_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  stall,
	input  logic                  branch_taken,
	input  logic [`MIPS_XLEN-1:0] branch_target,
	input  logic [`MIPS_XLEN-1:0] imem_data,
	output logic [`MIPS_XLEN-1:0] imem_addr,
	output logic [`MIPS_XLEN-1:0] id_pc,
	output isa_pkg::inst_t        id_inst
);

	logic [`MIPS_XLEN-1:0] pc;

	assign imem_addr = pc;

	// Redirect lands after the delay slot, which is already in fetch
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= `MIPS_RESET_PC;
		else if (!stall) begin
			if (branch_taken)
				pc <= branch_target;
			else
				pc <= pc + `MIPS_XLEN'd4;
		end
	end

	// IF/ID, an all-zero word decodes as a nop
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_pc   <= `MIPS_RESET_PC;
			id_inst <= '0;
		end else if (!stall) begin
			id_pc   <= pc;
			id_inst <= imem_data;
		end
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		imem_addr[1:0] == 2'b00);

endmodule

// File: hdl/decode_stage.sv
`include "mips_cfg.svh"

module decode_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`MIPS_XLEN-1:0] id_pc,
	input  isa_pkg::inst_t        id_inst,
	input  logic [`MIPS_XLEN-1:0] rdata1,
	input  logic [`MIPS_XLEN-1:0] rdata2,
	input  logic [`MIPS_XLEN-1:0] ex_result,
	input  logic                  ex_is_load,
	input  logic                  mem_we,
	input  logic [4:0]            mem_waddr,
	input  logic [`MIPS_XLEN-1:0] mem_result,
	output logic [4:0]            raddr1,
	output logic [4:0]            raddr2,
	output logic                  stall,
	output logic                  branch_taken,
	output logic [`MIPS_XLEN-1:0] branch_target,
	output logic [3:0]            ex_alu_op,
	output logic [`MIPS_XLEN-1:0] ex_a,
	output logic [`MIPS_XLEN-1:0] ex_b,
	output logic [`MIPS_XLEN-1:0] ex_store_data,
	output logic [1:0]            ex_mem_kind,
	output logic                  ex_we,
	output logic [4:0]            ex_waddr
);

	logic [5:0]            opcode;
	logic [4:0]            rs;
	logic [4:0]            rt;
	logic [`MIPS_XLEN-1:0] imm_sext;
	logic [`MIPS_XLEN-1:0] imm_zext;
	logic [`MIPS_XLEN-1:0] pc_plus4;
	logic [`MIPS_XLEN-1:0] op_rs;
	logic [`MIPS_XLEN-1:0] op_rt;
	logic                  use_rs;
	logic                  use_rt;
	logic                  take;
	logic [3:0]            alu_op;
	logic [`MIPS_XLEN-1:0] a;
	logic [`MIPS_XLEN-1:0] b;
	logic [1:0]            mem_kind;
	logic                  we;
	logic [4:0]            waddr;

	assign opcode   = id_inst.r.opcode;
	assign rs       = id_inst.i.rs;
	assign rt       = id_inst.i.rt;
	assign raddr1   = rs;
	assign raddr2   = rt;
	assign imm_sext = {{(`MIPS_XLEN-16){id_inst.i.imm[15]}}, id_inst.i.imm};
	assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, id_inst.i.imm};
	assign pc_plus4 = id_pc + `MIPS_XLEN'd4;

	// EX wins over MEM over the register file
	assign op_rs = (ex_we && ex_waddr == rs) ? ex_result :
		(mem_we && mem_waddr == rs) ? mem_result : rdata1;
	assign op_rt = (ex_we && ex_waddr == rt) ? ex_result :
		(mem_we && mem_waddr == rt) ? mem_result : rdata2;

	always_comb begin
		alu_op   = pipe_pkg::ALU_ADD;
		a        = op_rs;
		b        = op_rt;
		mem_kind = pipe_pkg::MEM_NONE;
		we       = 1'b0;
		waddr    = rt;
		use_rs   = 1'b0;
		use_rt   = 1'b0;
		take     = 1'b0;
		case (opcode)
			isa_pkg::OP_SPECIAL: begin
				waddr  = id_inst.r.rd;
				we     = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
				case (id_inst.r.funct)
					isa_pkg::FN_ADDU: alu_op = pipe_pkg::ALU_ADD;
					isa_pkg::FN_SUBU: alu_op = pipe_pkg::ALU_SUB;
					isa_pkg::FN_AND:  alu_op = pipe_pkg::ALU_AND;
					isa_pkg::FN_OR:   alu_op = pipe_pkg::ALU_OR;
					isa_pkg::FN_XOR:  alu_op = pipe_pkg::ALU_XOR;
					isa_pkg::FN_SLT:  alu_op = pipe_pkg::ALU_SLT;
					isa_pkg::FN_SLL: begin
						alu_op = pipe_pkg::ALU_SLL;
						a      = op_rt;
						b      = {{(`MIPS_XLEN-5){1'b0}}, id_inst.r.shamt};
						use_rs = 1'b0;
					end
					default: begin
						we     = 1'b0;
						use_rs = 1'b0;
						use_rt = 1'b0;
					end
				endcase
			end
			isa_pkg::OP_ADDIU: begin
				b      = imm_sext;
				we     = 1'b1;
				use_rs = 1'b1;
			end
			isa_pkg::OP_ORI: begin
				alu_op = pipe_pkg::ALU_OR;
				b      = imm_zext;
				we     = 1'b1;
				use_rs = 1'b1;
			end
			isa_pkg::OP_LUI: begin
				alu_op = pipe_pkg::ALU_LUI;
				b      = imm_zext;
				we     = 1'b1;
			end
			isa_pkg::OP_LW: begin
				b        = imm_sext;
				mem_kind = pipe_pkg::MEM_LOAD;
				we       = 1'b1;
				use_rs   = 1'b1;
			end
			isa_pkg::OP_SW: begin
				b        = imm_sext;
				mem_kind = pipe_pkg::MEM_STORE;
				use_rs   = 1'b1;
				use_rt   = 1'b1;
			end
			isa_pkg::OP_BEQ: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				take   = (op_rs == op_rt);
			end
			isa_pkg::OP_BNE: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				take   = (op_rs != op_rt);
			end
			isa_pkg::OP_J: take = 1'b1;
			default: ;
		endcase
	end

	// Jump keeps the upper bits of the delay slot address
	assign branch_target = (opcode == isa_pkg::OP_J) ?
		{pc_plus4[`MIPS_XLEN-1:28], id_inst[25:0], 2'b00} :
		pc_plus4 + {imm_sext[`MIPS_XLEN-3:0], 2'b00};

	// Load result is not ready until MEM
	assign stall = ex_is_load && ex_we &&
		((use_rs && ex_waddr == rs) || (use_rt && ex_waddr == rt));
	assign branch_taken = take && !stall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_we       <= 1'b0;
			ex_mem_kind <= pipe_pkg::MEM_NONE;
		end else if (stall) begin
			ex_we       <= 1'b0;
			ex_mem_kind <= pipe_pkg::MEM_NONE;
		end else begin
			ex_we       <= we && waddr != 5'd0;
			ex_mem_kind <= mem_kind;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op     <= alu_op;
		ex_a          <= a;
		ex_b          <= b;
		ex_store_data <= op_rt;
		ex_waddr      <= waddr;
	end

	// Fetch acts on both every cycle
	a_redirect_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({stall, branch_taken}));

endmodule

// File: hdl/execute_stage.sv
`include "mips_cfg.svh"

module execute_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [3:0]            alu_op,
	input  logic [`MIPS_XLEN-1:0] a,
	input  logic [`MIPS_XLEN-1:0] b,
	input  logic [`MIPS_XLEN-1:0] store_data,
	input  logic [1:0]            mem_kind,
	input  logic                  we,
	input  logic [4:0]            waddr,
	output logic [`MIPS_XLEN-1:0] result,
	output logic                  is_load,
	output logic [`MIPS_XLEN-1:0] mem_addr,
	output logic [`MIPS_XLEN-1:0] mem_store_data,
	output logic [1:0]            mem_kind_q,
	output logic                  mem_we,
	output logic [4:0]            mem_waddr
);

	logic slt;

	assign slt     = $signed(a) < $signed(b);
	assign is_load = (mem_kind == pipe_pkg::MEM_LOAD);

	// Loads and stores use ALU_ADD for base plus offset
	always_comb begin
		case (alu_op)
			pipe_pkg::ALU_ADD: result = a + b;
			pipe_pkg::ALU_SUB: result = a - b;
			pipe_pkg::ALU_AND: result = a & b;
			pipe_pkg::ALU_OR:  result = a | b;
			pipe_pkg::ALU_XOR: result = a ^ b;
			pipe_pkg::ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, slt};
			pipe_pkg::ALU_SLL: result = a << b[4:0];
			pipe_pkg::ALU_LUI: result = {b[15:0], {(`MIPS_XLEN-16){1'b0}}};
			default:           result = a + b;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_we     <= 1'b0;
			mem_kind_q <= pipe_pkg::MEM_NONE;
		end else begin
			mem_we     <= we;
			mem_kind_q <= mem_kind;
		end
	end

	always_ff @(posedge clk) begin
		mem_addr       <= result;
		mem_store_data <= store_data;
		mem_waddr      <= waddr;
	end

endmodule

// File: hdl/mem_stage.sv
`include "mips_cfg.svh"

module mem_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`MIPS_XLEN-1:0] addr,
	input  logic [`MIPS_XLEN-1:0] store_data,
	input  logic [1:0]            kind,
	input  logic                  we,
	input  logic [4:0]            waddr,
	input  logic [`MIPS_XLEN-1:0] dmem_rdata,
	output logic [`MIPS_XLEN-1:0] dmem_addr,
	output logic [`MIPS_XLEN-1:0] dmem_wdata,
	output logic                  dmem_we,
	output logic                  dmem_re,
	output logic [`MIPS_XLEN-1:0] fwd_result,
	output logic                  wb_we,
	output logic [4:0]            wb_waddr,
	output logic [`MIPS_XLEN-1:0] wb_wdata
);

	assign dmem_addr  = addr;
	assign dmem_wdata = store_data;
	assign dmem_we    = (kind == pipe_pkg::MEM_STORE);
	assign dmem_re    = (kind == pipe_pkg::MEM_LOAD);

	// Read data returns within the cycle
	assign fwd_result = dmem_re ? dmem_rdata : addr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_we <= 1'b0;
		else
			wb_we <= we;
	end

	always_ff @(posedge clk) begin
		wb_waddr <= waddr;
		wb_wdata <= fwd_result;
	end

	// Word accesses only
	a_access_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		(dmem_we || dmem_re) |-> dmem_addr[1:0] == 2'b00);

endmodule

// File: hdl/trivial_mips.sv
`include "mips_cfg.svh"

module trivial_mips (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`MIPS_XLEN-1:0] imem_data,
	input  logic [`MIPS_XLEN-1:0] dmem_rdata,
	output logic [`MIPS_XLEN-1:0] imem_addr,
	output logic [`MIPS_XLEN-1:0] dmem_addr,
	output logic [`MIPS_XLEN-1:0] dmem_wdata,
	output logic                  dmem_we,
	output logic                  dmem_re,
	output logic                  wb_we,
	output logic [4:0]            wb_waddr,
	output logic [`MIPS_XLEN-1:0] wb_wdata
);

	logic [4:0]            raddr1;
	logic [4:0]            raddr2;
	logic [`MIPS_XLEN-1:0] rdata1;
	logic [`MIPS_XLEN-1:0] rdata2;

	logic                  stall;
	logic                  branch_taken;
	logic [`MIPS_XLEN-1:0] branch_target;
	logic [`MIPS_XLEN-1:0] id_pc;
	isa_pkg::inst_t        id_inst;

	logic [3:0]            ex_alu_op;
	logic [`MIPS_XLEN-1:0] ex_a;
	logic [`MIPS_XLEN-1:0] ex_b;
	logic [`MIPS_XLEN-1:0] ex_store_data;
	logic [1:0]            ex_mem_kind;
	logic                  ex_we;
	logic [4:0]            ex_waddr;
	logic [`MIPS_XLEN-1:0] ex_result;
	logic                  ex_is_load;

	logic [`MIPS_XLEN-1:0] mem_addr;
	logic [`MIPS_XLEN-1:0] mem_store_data;
	logic [1:0]            mem_kind;
	logic                  mem_we;
	logic [4:0]            mem_waddr;
	logic [`MIPS_XLEN-1:0] mem_result;

	// WB writes the register file and the trace port together
	reg_file i_reg_file (
		.clk, .arst_n,
		.we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata),
		.raddr1, .raddr2, .rdata1, .rdata2
	);

	fetch_stage i_fetch_stage (
		.clk, .arst_n, .stall, .branch_taken, .branch_target,
		.imem_data, .imem_addr, .id_pc, .id_inst
	);

	decode_stage i_decode_stage (
		.clk, .arst_n, .id_pc, .id_inst, .rdata1, .rdata2,
		.ex_result, .ex_is_load, .mem_we, .mem_waddr, .mem_result,
		.raddr1, .raddr2, .stall, .branch_taken, .branch_target,
		.ex_alu_op, .ex_a, .ex_b, .ex_store_data, .ex_mem_kind, .ex_we, .ex_waddr
	);

	execute_stage i_execute_stage (
		.clk, .arst_n,
		.alu_op(ex_alu_op), .a(ex_a), .b(ex_b), .store_data(ex_store_data),
		.mem_kind(ex_mem_kind), .we(ex_we), .waddr(ex_waddr),
		.result(ex_result), .is_load(ex_is_load),
		.mem_addr, .mem_store_data, .mem_kind_q(mem_kind), .mem_we, .mem_waddr
	);

	mem_stage i_mem_stage (
		.clk, .arst_n,
		.addr(mem_addr), .store_data(mem_store_data), .kind(mem_kind),
		.we(mem_we), .waddr(mem_waddr), .dmem_rdata,
		.dmem_addr, .dmem_wdata, .dmem_we, .dmem_re,
		.fwd_result(mem_result), .wb_we, .wb_waddr, .wb_wdata
	);

endmodule

// File: tests/tb_trivial_mips.sv
`include "mips_cfg.svh"

module tb_trivial_mips;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int DRAIN_CYCLES   = 20;

	logic                  clk = 1'b0;
	logic                  arst_n;
	logic [`MIPS_XLEN-1:0] imem_data;
	logic [`MIPS_XLEN-1:0] dmem_rdata;
	logic [`MIPS_XLEN-1:0] imem_addr;
	logic [`MIPS_XLEN-1:0] dmem_addr;
	logic [`MIPS_XLEN-1:0] dmem_wdata;
	logic                  dmem_we;
	logic                  dmem_re;
	logic                  wb_we;
	logic [4:0]            wb_waddr;
	logic [`MIPS_XLEN-1:0] wb_wdata;

	// Word addressed memories of 256 words
	logic [`MIPS_XLEN-1:0] imem [256];
	logic [`MIPS_XLEN-1:0] dmem [256];

	logic [4:0]            exp_wb_reg [$];
	logic [`MIPS_XLEN-1:0] exp_wb_val [$];
	logic [`MIPS_XLEN-1:0] exp_st_addr [$];
	logic [`MIPS_XLEN-1:0] exp_st_val [$];

	int wb_errors;
	int store_errors;
	int extra_errors;
	int other_errors;

	trivial_mips i_trivial_mips (
		.clk, .arst_n, .imem_data, .dmem_rdata, .imem_addr,
		.dmem_addr, .dmem_wdata, .dmem_we, .dmem_re,
		.wb_we, .wb_waddr, .wb_wdata
	);

	always #10 clk = ~clk;

	// Both memories answer within the cycle
	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : '0;

	always @(posedge clk) begin
		if (dmem_we)
			dmem[dmem_addr[9:2]] <= dmem_wdata;
	end

	function automatic string mnemonic(input isa_pkg::inst_t w);
		string s;
		case (w.r.opcode)
			isa_pkg::OP_SPECIAL: begin
				case (w.r.funct)
					isa_pkg::FN_ADDU: s = "addu";
					isa_pkg::FN_SUBU: s = "subu";
					isa_pkg::FN_AND:  s = "and";
					isa_pkg::FN_OR:   s = "or";
					isa_pkg::FN_XOR:  s = "xor";
					isa_pkg::FN_SLT:  s = "slt";
					isa_pkg::FN_SLL:  s = (w.r.rd == 5'd0) ? "nop" : "sll";
					default:          s = "special?";
				endcase
			end
			isa_pkg::OP_ADDIU: s = "addiu";
			isa_pkg::OP_ORI:   s = "ori";
			isa_pkg::OP_LUI:   s = "lui";
			isa_pkg::OP_LW:    s = "lw";
			isa_pkg::OP_SW:    s = "sw";
			isa_pkg::OP_BEQ:   s = "beq";
			isa_pkg::OP_BNE:   s = "bne";
			isa_pkg::OP_J:     s = "j";
			default:           s = "unknown";
		endcase
		return s;
	endfunction

	task automatic check_wb(input logic [4:0] exp_reg, input logic [`MIPS_XLEN-1:0] exp_val,
		input logic [4:0] got_reg, input logic [`MIPS_XLEN-1:0] got_val);
		if (got_reg !== exp_reg || got_val !== exp_val) begin
			$display("[FAIL] %0t ns: write-back expected r%0d = %08h, got r%0d = %08h",
				$time, exp_reg, exp_val, got_reg, got_val);
			wb_errors++;
		end
	endtask

	task automatic check_store(input logic [`MIPS_XLEN-1:0] exp_addr,
		input logic [`MIPS_XLEN-1:0] exp_val, input logic [`MIPS_XLEN-1:0] got_addr,
		input logic [`MIPS_XLEN-1:0] got_val);
		if (got_addr !== exp_addr || got_val !== exp_val) begin
			$display("[FAIL] %0t ns: store expected [%08h] = %08h, got [%08h] = %08h",
				$time, exp_addr, exp_val, got_addr, got_val);
			store_errors++;
		end
	endtask

	// Outputs have settled by the falling edge
	always @(negedge clk) begin
		if (arst_n && wb_we) begin
			if (exp_wb_reg.size() == 0) begin
				$display("%0t ns: write-back r%0d = %08h after the last expected one",
					$time, wb_waddr, wb_wdata);
				extra_errors++;
			end else begin
				check_wb(exp_wb_reg.pop_front(), exp_wb_val.pop_front(),
					wb_waddr, wb_wdata);
			end
		end
		if (arst_n && dmem_we) begin
			if (exp_st_addr.size() == 0) begin
				$display("%0t ns: store [%08h] = %08h after the last expected one",
					$time, dmem_addr, dmem_wdata);
				extra_errors++;
			end else begin
				check_store(exp_st_addr.pop_front(), exp_st_val.pop_front(),
					dmem_addr, dmem_wdata);
			end
		end
		if (arst_n && dmem_we && dmem_re) begin
			$display("%0t ns: data memory read and write strobes are high together", $time);
			other_errors++;
		end
	end

	task automatic load_vectors();
		int          fd;
		int          n;
		int          i;
		string       line;
		logic [7:0]  tag;
		logic [31:0] a;
		logic [31:0] v;
		for (i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] <= {8'hd0, i[7:0], ~i[7:0], i[7:0]};
		end
		fd = $fopen("tests/mips_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/mips_vectors.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				if ($sscanf(line, "%c %h %h", tag, a, v) == 3) begin
					case (tag)
						"I": imem[a[9:2]] = v;
						"D": dmem[a[9:2]] <= v;
						"W": begin
							exp_wb_reg.push_back(a[4:0]);
							exp_wb_val.push_back(v);
						end
						"S": begin
							exp_st_addr.push_back(a);
							exp_st_val.push_back(v);
						end
						default: begin
							$display("vector file line has an unknown tag: %s", line);
							other_errors++;
						end
					endcase
				end
			end
		end
		$fclose(fd);
		if (exp_wb_reg.size() == 0) begin
			$display("vector file lists no expected write-backs");
			other_errors++;
		end
	endtask

	task automatic wait_retired();
		int             cycles;
		isa_pkg::inst_t word;
		cycles = 0;
		while ((exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) &&
			cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) begin
			word = imem[imem_addr[9:2]];
			$display("timeout waiting for write-back: %0d writes and %0d stores missing",
				exp_wb_reg.size(), exp_st_addr.size());
			$display("fetch stuck at %08h on %s", imem_addr, mnemonic(word));
			other_errors++;
		end
	endtask

	initial begin
		arst_n = 1'b0;
		load_vectors();
		if (other_errors == 0) begin
			repeat (5) @(posedge clk);
			arst_n <= 1'b1;
			wait_retired();
			// Anything retiring here is beyond the list
			repeat (DRAIN_CYCLES) @(posedge clk);
		end
		$display("errors: write-back %0d, store %0d, extra %0d, other %0d",
			wb_errors, store_errors, extra_errors, other_errors);
		if (wb_errors + store_errors + extra_errors + other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: tests/mips_vectors.txt
# Columns: tag addr word, all hex. I program word, D initial data word
# W reg value is the next register write, S addr value the next store
I 00000000 34011234 ori   r1, r0, 0x1234
I 00000004 2402fffb addiu r2, r0, -5
I 00000008 3c03abcd lui   r3, 0xabcd
I 0000000c 00222021 addu  r4, r1, r2
I 00000010 00812823 subu  r5, r4, r1
I 00000014 00613025 or    r6, r3, r1
I 00000018 00c23824 and   r7, r6, r2
I 0000001c 00e14026 xor   r8, r7, r1
I 00000020 0041482a slt   r9, r2, r1
I 00000024 0022502a slt   r10, r1, r2
I 00000028 00015900 sll   r11, r1, 4
I 0000002c 24200005 addiu r0, r1, 5
I 00000030 240c0040 addiu r12, r0, 0x40
I 00000034 ad880000 sw    r8, 0(r12)
I 00000038 ad8b0004 sw    r11, 4(r12)
I 0000003c 8d8d0000 lw    r13, 0(r12)
I 00000040 01a17021 addu  r14, r13, r1
I 00000044 8d8f0008 lw    r15, 8(r12)
I 00000048 341000ff ori   r16, r0, 0xff
I 0000004c 01f08823 subu  r17, r15, r16
I 00000050 10240002 beq   r1, r4, +2
I 00000054 24120001 addiu r18, r0, 1
I 00000058 14240002 bne   r1, r4, +2
I 0000005c 24130002 addiu r19, r0, 2
I 00000060 24140099 addiu r20, r0, 0x99
I 00000064 16600002 bne   r19, r0, +2
I 00000068 34155555 ori   r21, r0, 0x5555
I 0000006c 24140077 addiu r20, r0, 0x77
I 00000070 12a00003 beq   r21, r0, +3
I 00000074 24160003 addiu r22, r0, 3
I 00000078 08000021 j     0x84
I 0000007c 24170004 addiu r23, r0, 4
I 00000080 24140066 addiu r20, r0, 0x66
I 00000084 02d7c021 addu  r24, r22, r23
I 00000088 ad980008 sw    r24, 8(r12)
I 0000008c 8d990008 lw    r25, 8(r12)
I 00000090 13380001 beq   r25, r24, +1
I 00000094 241a0005 addiu r26, r0, 5
I 00000098 08000026 j     0x98
I 0000009c 00000000 nop
D 00000048 13579bdf
W 01 00001234
W 02 fffffffb
W 03 abcd0000
W 04 0000122f
W 05 fffffffb
W 06 abcd1234
W 07 abcd1230
W 08 abcd0004
W 09 00000001
W 0a 00000000
W 0b 00012340
W 0c 00000040
W 0d abcd0004
W 0e abcd1238
W 0f 13579bdf
W 10 000000ff
W 11 13579ae0
W 12 00000001
W 13 00000002
W 15 00005555
W 16 00000003
W 17 00000004
W 18 00000007
W 19 00000007
W 1a 00000005
S 00000040 abcd0004
S 00000044 00012340
S 00000048 00000007

// File: build.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/trivial_mips.sv
tests/tb_trivial_mips.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for a failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_trivial_mips -f build.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
